//--- logic/ci_column_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ci_column_adder (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic [ci_pkg::PIX_W-1:0]    s1,
  input  wire logic [ci_pkg::PIX_W-1:0]    s2,
  input  wire logic [ci_pkg::PIX_W-1:0]    s3,
  input  wire logic [ci_pkg::PIX_W-1:0]    s4,
  input  wire logic [ci_pkg::PIX_W-1:0]    s5,
  input  wire logic [ci_pkg::PIX_W-1:0]    s6,
  input  wire logic [ci_pkg::PIX_W-1:0]    s7,
  input  wire logic [ci_pkg::PIX_W-1:0]    s8,
  input  wire logic [ci_pkg::PIX_W-1:0]    s9,
  input  wire logic [ci_pkg::PIX_W-1:0]    s10,
  input  wire logic [ci_pkg::PIX_W-1:0]    s11,
  input  wire logic [ci_pkg::PIX_W-1:0]    s12,
  input  wire logic [ci_pkg::PIX_W-1:0]    s13,
  output logic      [ci_pkg::COL_SUM_W-1:0] col_sum,
  output logic      [ci_pkg::PIX_W-1:0]    col_center
);

  logic [ci_pkg::PIX_W:0]   pair_a, pair_b, pair_c, pair_d, pair_e, pair_f;
  logic [ci_pkg::PIX_W+1:0] quad_a, quad_b, quad_c;
  logic [ci_pkg::PIX_W+2:0] oct_a;
  ci_pkg::col_sum_t         tree_sum;

  // Balanced tree where s13 joins at the last level
  always_comb begin
    pair_a = {1'b0, s1} + {1'b0, s2};
    pair_b = {1'b0, s3} + {1'b0, s4};
    pair_c = {1'b0, s5} + {1'b0, s6};
    pair_d = {1'b0, s7} + {1'b0, s8};
    pair_e = {1'b0, s9} + {1'b0, s10};
    pair_f = {1'b0, s11} + {1'b0, s12};
    quad_a = {1'b0, pair_a} + {1'b0, pair_b};
    quad_b = {1'b0, pair_c} + {1'b0, pair_d};
    quad_c = {1'b0, pair_e} + {1'b0, pair_f};
    oct_a  = {1'b0, quad_a} + {1'b0, quad_b};
    tree_sum = ci_pkg::col_sum_t'(oct_a) + ci_pkg::col_sum_t'(quad_c)
             + ci_pkg::col_sum_t'(s13);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_sum    <= '0;
      col_center <= '0;
    end else begin
      col_sum    <= tree_sum;
      col_center <= s7;  // Middle row of the strip
    end
  end

endmodule

`default_nettype wire

//--- logic/ci_controller.sv
`timescale 1ns/1ps
`default_nettype none

module ci_controller (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic done_i,
  output logic      shift_en,
  output logic      clear_en,
  output logic      win_valid,
  output logic      image_done
);

  ci_pkg::ctrl_state_t state;
  ci_pkg::cnt_t        col_cnt;
  ci_pkg::cnt_t        strip_cnt;
  logic                accept;
  logic                last_col;
  logic                last_strip;
  logic                win_pend;
  logic                last_pend;

  always_comb begin
    accept     = done_i && (state != ci_pkg::ST_DONE);  // Columns after the image are dropped
    last_col   = col_cnt == ci_pkg::cnt_t'(ci_pkg::COLS_MAX - 1);
    last_strip = strip_cnt == ci_pkg::cnt_t'(ci_pkg::ROWS_MAX - ci_pkg::WIN);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ci_pkg::ST_IDLE;
    end else begin
      case (state)
        ci_pkg::ST_IDLE: begin
          if (done_i) begin
            state <= ci_pkg::ST_STRIP;
          end
        end
        ci_pkg::ST_STRIP: begin
          if (done_i && last_col && last_strip) begin
            state <= ci_pkg::ST_DONE;
          end
        end
        default: state <= ci_pkg::ST_DONE;  // Held until reset
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt   <= '0;
      strip_cnt <= '0;
    end else if (accept) begin
      if (last_col) begin
        col_cnt   <= '0;
        strip_cnt <= last_strip ? '0 : strip_cnt + ci_pkg::cnt_t'(1);
      end else begin
        col_cnt <= col_cnt + ci_pkg::cnt_t'(1);
      end
    end
  end

  // Decisions are taken on the accepted column and issued a cycle later so
  // that they line up with the registered column sum
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_en   <= 1'b0;
      clear_en   <= 1'b0;
      win_pend   <= 1'b0;
      last_pend  <= 1'b0;
      win_valid  <= 1'b0;
      image_done <= 1'b0;
    end else begin
      shift_en   <= accept;
      clear_en   <= accept && (col_cnt == '0);
      win_pend   <= accept && (col_cnt >= ci_pkg::cnt_t'(ci_pkg::WIN - 1));
      last_pend  <= accept && last_col && last_strip;
      win_valid  <= win_pend;  // Window sum settles on this edge
      image_done <= last_pend;
    end
  end

  a_col_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    col_cnt < ci_pkg::cnt_t'(ci_pkg::COLS_MAX)
  ) else $error("Column counter out of range %0d", col_cnt);

  a_valid_after_shift : assert property (
    @(posedge clk) disable iff (!rst_n)
    win_valid |-> $past(shift_en)
  ) else $error("Window valid without a preceding shift");

endmodule

`default_nettype wire

//--- logic/ci_pkg.sv
`default_nettype none

package ci_pkg;

  // Window geometry for radius 6
  localparam int WIN = 13;
  localparam int WIN_AREA = WIN * WIN;  // Multiplier applied to the center pixel
  localparam int CENTER_IDX = WIN / 2;

  // One strip of the image is WIN rows high
  localparam int COLS_MAX = 15;
  localparam int ROWS_MAX = 15;  // Gives ROWS_MAX - 12 strips

  // Data path and counter widths
  localparam int PIX_W = 8;
  localparam int COL_SUM_W = 12;  // 13 x 255 fits
  localparam int WIN_SUM_W = 16;  // 169 x 255 fits
  localparam int CNT_W = 10;

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [COL_SUM_W-1:0] col_sum_t;
  typedef logic [WIN_SUM_W-1:0] win_sum_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STRIP,
    ST_DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/ci_window_sum.sv
`timescale 1ns/1ps
`default_nettype none

module ci_window_sum (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         shift_en,
  input  wire logic                         clear_en,
  input  wire logic [ci_pkg::COL_SUM_W-1:0] col_sum,
  input  wire logic [ci_pkg::PIX_W-1:0]     col_center,
  output logic      [ci_pkg::WIN_SUM_W-1:0] win_sum,
  output logic      [ci_pkg::PIX_W-1:0]     win_center
);

  // Entry 0 holds the newest column
  ci_pkg::col_sum_t         sum_hist    [ci_pkg::WIN];
  logic [ci_pkg::PIX_W-1:0] center_hist [ci_pkg::CENTER_IDX+1];
  ci_pkg::win_sum_t         next_sum;

  // Add the arriving column and drop the one that leaves the window
  always_comb begin
    next_sum = win_sum + ci_pkg::win_sum_t'(col_sum)
             - ci_pkg::win_sum_t'(sum_hist[ci_pkg::WIN-1]);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_sum <= '0;
    end else if (shift_en) begin
      if (clear_en) begin
        win_sum <= ci_pkg::win_sum_t'(col_sum);  // First column of a strip
      end else begin
        win_sum <= next_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (shift_en) begin
      sum_hist[0] <= col_sum;
      for (int i = 1; i < ci_pkg::WIN; i++) begin
        // Zeroed history makes the subtraction a no-op for the first columns
        sum_hist[i] <= clear_en ? '0 : sum_hist[i-1];
      end
    end
  end

  // Delay line that carries each column center six shifts along
  always_ff @(posedge clk) begin
    if (shift_en) begin
      center_hist[0] <= col_center;
      for (int i = 1; i <= ci_pkg::CENTER_IDX; i++) begin
        center_hist[i] <= center_hist[i-1];
      end
    end
  end

  assign win_center = center_hist[ci_pkg::CENTER_IDX];  // Column six back from the newest

  // The running sum must stay within a full window of white pixels
  a_win_sum_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    win_sum <= ci_pkg::win_sum_t'(ci_pkg::WIN_AREA * ((1 << ci_pkg::PIX_W) - 1))
  ) else $error("Window sum %0d exceeds the largest possible window", win_sum);

endmodule

`default_nettype wire

//--- logic/mrelbp_ci.sv
`timescale 1ns/1ps
`default_nettype none

module mrelbp_ci (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     done_i,
  input  wire logic [ci_pkg::PIX_W-1:0] s1,
  input  wire logic [ci_pkg::PIX_W-1:0] s2,
  input  wire logic [ci_pkg::PIX_W-1:0] s3,
  input  wire logic [ci_pkg::PIX_W-1:0] s4,
  input  wire logic [ci_pkg::PIX_W-1:0] s5,
  input  wire logic [ci_pkg::PIX_W-1:0] s6,
  input  wire logic [ci_pkg::PIX_W-1:0] s7,
  input  wire logic [ci_pkg::PIX_W-1:0] s8,
  input  wire logic [ci_pkg::PIX_W-1:0] s9,
  input  wire logic [ci_pkg::PIX_W-1:0] s10,
  input  wire logic [ci_pkg::PIX_W-1:0] s11,
  input  wire logic [ci_pkg::PIX_W-1:0] s12,
  input  wire logic [ci_pkg::PIX_W-1:0] s13,
  output logic                          ci_o,
  output logic                          done_o,
  output logic                          progress_done_o
);

  logic                         shift_en;
  logic                         clear_en;
  logic                         win_valid;
  logic                         image_done;
  logic [ci_pkg::COL_SUM_W-1:0] col_sum;
  logic [ci_pkg::PIX_W-1:0]     col_center;
  logic [ci_pkg::WIN_SUM_W-1:0] win_sum;
  logic [ci_pkg::PIX_W-1:0]     win_center;
  ci_pkg::win_sum_t             center_scaled;

  ci_controller i_controller (
    .clk        (clk),
    .rst_n      (rst_n),
    .done_i     (done_i),
    .shift_en   (shift_en),
    .clear_en   (clear_en),
    .win_valid  (win_valid),
    .image_done (image_done)
  );

  ci_column_adder i_column_adder (
    .clk        (clk),
    .rst_n      (rst_n),
    .s1         (s1),
    .s2         (s2),
    .s3         (s3),
    .s4         (s4),
    .s5         (s5),
    .s6         (s6),
    .s7         (s7),
    .s8         (s8),
    .s9         (s9),
    .s10        (s10),
    .s11        (s11),
    .s12        (s12),
    .s13        (s13),
    .col_sum    (col_sum),
    .col_center (col_center)
  );

  ci_window_sum i_window_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en   (shift_en),
    .clear_en   (clear_en),
    .col_sum    (col_sum),
    .col_center (col_center),
    .win_sum    (win_sum),
    .win_center (win_center)
  );

  // Center times area against the sum avoids dividing by the window size
  assign center_scaled = ci_pkg::win_sum_t'(win_center) * ci_pkg::win_sum_t'(ci_pkg::WIN_AREA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ci_o            <= 1'b0;
      done_o          <= 1'b0;
      progress_done_o <= 1'b0;
    end else begin
      done_o          <= win_valid;
      progress_done_o <= image_done;  // Lands with the final done_o
      if (win_valid) begin
        ci_o <= center_scaled >= win_sum;
      end
    end
  end

endmodule

`default_nettype wire

//--- mrelbp_ci.f
logic/ci_pkg.sv
logic/ci_column_adder.sv
logic/ci_window_sum.sv
logic/ci_controller.sv
logic/mrelbp_ci.sv
verif/ci_clock_gen.sv
verif/tb_mrelbp_ci.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mrelbp_ci -f mrelbp_ci.f -o tb_mrelbp_ci \
  || { echo "Build failed"; exit 1; }

out="$(./obj_dir/tb_mrelbp_ci)"
echo "$out"

grep -q "Verification passed" <<< "$out" \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run did not succeed"; exit 1; }

//--- verif/ci_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ci_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 20;  // 40 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

//--- verif/tb_mrelbp_ci.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mrelbp_ci;

  localparam int STRIPS = ci_pkg::ROWS_MAX - (ci_pkg::WIN - 1);
  localparam int WINDOWS = STRIPS * (ci_pkg::COLS_MAX - (ci_pkg::WIN - 1));
  localparam int CYCLE_LIMIT = 4 * (STRIPS * ci_pkg::COLS_MAX) + 100;
  localparam int RESET_CYCLES = 8;
  localparam int LATENCY = 3;
  localparam int DRIVE_DELAY = 2;

  logic                     clk;
  logic                     rst_n;
  logic                     done_i;
  logic [ci_pkg::PIX_W-1:0] pix [ci_pkg::WIN];  // Index 0 drives s1
  logic                     ci_o;
  logic                     done_o;
  logic                     progress_done_o;

  integer                   seed;
  logic [ci_pkg::PIX_W-1:0] flat_level;
  logic [ci_pkg::PIX_W-1:0] strip_pix [ci_pkg::COLS_MAX][ci_pkg::WIN];
  int  errors = 0;
  int  checks = 0;
  int  cycle = 0;
  int  done_count = 0;
  int  progress_count = 0;
  int  model_col = 0;
  int  model_strip = 0;
  bit  model_done = 1'b0;
  bit  exp_ci_q[$];
  int  exp_cycle_q[$];
  bit  exp_last_q[$];
  int  exp_strip_q[$];

  ci_clock_gen i_clock_gen (.clk(clk));

  mrelbp_ci i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .done_i          (done_i),
    .s1              (pix[0]),
    .s2              (pix[1]),
    .s3              (pix[2]),
    .s4              (pix[3]),
    .s5              (pix[4]),
    .s6              (pix[5]),
    .s7              (pix[6]),
    .s8              (pix[7]),
    .s9              (pix[8]),
    .s10             (pix[9]),
    .s11             (pix[10]),
    .s12             (pix[11]),
    .s13             (pix[12]),
    .ci_o            (ci_o),
    .done_o          (done_o),
    .progress_done_o (progress_done_o)
  );

  task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic load_idle();
    for (int r = 0; r < ci_pkg::WIN; r++) begin
      pix[r] = 8'($random(seed));  // Noise on an idle cycle must be ignored
    end
    done_i = 1'b0;
  endtask

  task automatic load_column(input int strip, input int col);
    for (int r = 0; r < ci_pkg::WIN; r++) begin
      if (strip == 0) begin
        pix[r] = flat_level;  // A flat strip has its center equal to the mean
      end else begin
        pix[r] = 8'($random(seed));
      end
    end
    if (strip == 1) begin
      pix[0] = pix[0] | 8'h01;  // Every window keeps a nonzero neighbor
      if (col >= ci_pkg::CENTER_IDX && col <= ci_pkg::COLS_MAX - 1 - ci_pkg::CENTER_IDX) begin
        pix[ci_pkg::CENTER_IDX] = '0;
      end
    end
    done_i = 1'b1;
  endtask

  // Window ending at the newest column of the strip
  task automatic record_column();
    int sum;
    int center;
    bit last;
    for (int r = 0; r < ci_pkg::WIN; r++) begin
      strip_pix[model_col][r] = pix[r];
    end
    if (model_col >= ci_pkg::WIN - 1) begin
      sum = 0;
      for (int c = model_col - (ci_pkg::WIN - 1); c <= model_col; c++) begin
        for (int r = 0; r < ci_pkg::WIN; r++) begin
          sum = sum + int'(strip_pix[c][r]);
        end
      end
      center = int'(strip_pix[model_col - ci_pkg::CENTER_IDX][ci_pkg::CENTER_IDX]);
      last = (model_strip == STRIPS - 1) && (model_col == ci_pkg::COLS_MAX - 1);
      exp_ci_q.push_back(center * ci_pkg::WIN_AREA >= sum);
      exp_cycle_q.push_back(cycle + LATENCY);
      exp_last_q.push_back(last);
      exp_strip_q.push_back(model_strip);
    end
    if (model_col == ci_pkg::COLS_MAX - 1) begin
      model_col = 0;
      model_strip++;
      model_done = (model_strip == STRIPS);
    end else begin
      model_col++;
    end
  endtask

  task automatic check_output();
    bit exp_ci;
    int exp_cycle;
    bit exp_last;
    int exp_strip;
    if (done_o) begin
      done_count++;
      assert (exp_ci_q.size() > 0) else begin
        errors++;
        $display("done_o at %0d ns has no matching window in the model", $time);
      end
      if (exp_ci_q.size() > 0) begin
        exp_ci = exp_ci_q.pop_front();
        exp_cycle = exp_cycle_q.pop_front();
        exp_last = exp_last_q.pop_front();
        exp_strip = exp_strip_q.pop_front();
        checks++;
        assert (ci_o == exp_ci) else begin
          errors++;
          $display("Error at %0d ns: ci_o expected %0b, actual %0b", $time, exp_ci, ci_o);
        end
        assert (cycle == exp_cycle) else begin
          errors++;
          $display("Error at %0d ns: done_o cycle expected %0d, actual %0d",
                   $time, exp_cycle, cycle);
        end
        assert (progress_done_o == exp_last) else begin
          errors++;
          $display("Error at %0d ns: progress_done_o expected %0b, actual %0b",
                   $time, exp_last, progress_done_o);
        end
        if (exp_strip == 0) begin
          assert (ci_o == 1'b1) else begin
            errors++;
            $display("Error at %0d ns: ci_o expected 1, actual %0b (flat strip)", $time, ci_o);
          end
        end else if (exp_strip == 1) begin
          assert (ci_o == 1'b0) else begin
            errors++;
            $display("Error at %0d ns: ci_o expected 0, actual %0b (zero center)", $time, ci_o);
          end
        end
      end
    end else begin
      assert (!progress_done_o) else begin
        errors++;
        $display("Error at %0d ns: progress_done_o expected 0, actual %0b without done_o",
                 $time, progress_done_o);
      end
      if (done_count == 0) begin
        assert (!ci_o) else begin
          errors++;
          $display("Error at %0d ns: ci_o expected 0, actual %0b", $time, ci_o);
        end
      end
    end
    if (progress_done_o) begin
      progress_count++;
    end
  endtask

  // Outputs and done_i are stable at the falling edge
  always @(negedge clk) begin
    if (cycle > 0) begin  // Nothing is clocked before the first rising edge
      if (!rst_n) begin
        assert (!done_o && !ci_o && !progress_done_o) else begin
          errors++;
          $display("Error at %0d ns: done_o ci_o progress_done_o expected 000, actual %b%b%b",
                   $time, done_o, ci_o, progress_done_o);
        end
      end else begin
        check_output();
        if (done_i && !model_done) begin
          record_column();
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the image never completed", cycle);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int unsigned roll;
    seed = 32'h3942_ba46;
    rst_n = 1'b0;
    done_i = 1'b0;
    for (int r = 0; r < ci_pkg::WIN; r++) begin
      pix[r] = '0;
    end
    flat_level = 8'($random(seed));
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    for (int strip = 0; strip < STRIPS; strip++) begin
      for (int col = 0; col < ci_pkg::COLS_MAX; col++) begin
        roll = $random(seed);
        while (strip > 0 && roll % 10 < 3) begin  // Strip 0 runs without gaps
          step();
          load_idle();
          roll = $random(seed);
        end
        step();
        load_column(strip, col);
      end
    end
    repeat (20) begin
      step();
      load_idle();
      done_i = 1'($random(seed));  // Columns after the image must be dropped
    end
    step();
    done_i = 1'b0;
    repeat (LATENCY + 2) @(posedge clk);
    assert (done_count == WINDOWS) else begin
      errors++;
      $display("Error at %0d ns: done_o count expected %0d, actual %0d",
               $time, WINDOWS, done_count);
    end
    assert (progress_count == 1) else begin
      errors++;
      $display("Error at %0d ns: progress_done_o pulses expected 1, actual %0d",
               $time, progress_count);
    end
    assert (exp_ci_q.size() == 0) else begin
      errors++;
      $display("%0d expected windows never produced a done_o", exp_ci_q.size());
    end
    $display("Summary: %0d windows checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
